//--- sa_format_pkg.sv
package sa_format_pkg;

    // values carried per PE port, on both the pixel and the weight side
    parameter int lanes_per_port = 4;

    // one feature-map pixel, unsigned
    typedef logic [1:0] pixel_t;

    // one binary weight
    typedef logic weight_t;

    // packed operands as they travel through the array
    typedef logic [11:0] packed_pixel_t;
    typedef logic [20:0] packed_weight_t;

    // bit position of pixel a inside packed_pixel_t
    parameter int pixel_offset [lanes_per_port] = '{0, 2, 8, 10};

    // bit position of weight b inside packed_weight_t
    parameter int weight_offset [lanes_per_port] = '{0, 4, 16, 20};

    // 2 bits of product plus 6 bits headroom, wraps modulo 256
    typedef logic [7:0] acc_t;

    // sixteen fields per PE
    // field index is weight_idx * lanes_per_port + pixel_idx
    typedef acc_t [lanes_per_port*lanes_per_port-1:0] pe_result_t;

    // row number as carried in a readout word
    // the full readout struct depends on cols, so sa_tile_top builds it
    typedef logic [7:0] row_index_t;

endpackage

//--- sa_ctrl_pkg.sv
package sa_ctrl_pkg;

    // controller states
    // st_clear lasts one cycle and zeroes the accumulators
    // st_run feeds vectors until vector_last
    // st_drain lets the last wavefront reach the far corner
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_clear = 2'd1,
        st_run   = 2'd2,
        st_drain = 2'd3
    } ctrl_state_t;

    // drain cycle counter
    // rows + cols never exceeds 64
    typedef logic [7:0] drain_count_t;

endpackage

//--- pe_12_unsigned.sv
`timescale 1ns/1ps

module pe_12_unsigned (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           en,
    input  logic                           clear,
    input  sa_format_pkg::packed_weight_t  left,
    input  sa_format_pkg::packed_pixel_t   up,
    output sa_format_pkg::packed_weight_t  right,
    output sa_format_pkg::packed_pixel_t   bottom,
    output sa_format_pkg::pe_result_t      out
);
    import sa_format_pkg::*;

    // operand fields sliced out of the packed words
    pixel_t  [lanes_per_port-1:0] pixel;
    weight_t [lanes_per_port-1:0] weight;

    // accumulator value after this cycle's products
    pe_result_t acc_next;

    // unpack at fixed positions
    always_comb begin
        for (int a = 0; a < lanes_per_port; a++) begin
            pixel[a] = up[pixel_offset[a] +: $bits(pixel_t)];
        end
        for (int b = 0; b < lanes_per_port; b++) begin
            weight[b] = left[weight_offset[b]];
        end
    end

    // 1-bit weight times 2-bit pixel is just a masked pixel
    always_comb begin
        for (int b = 0; b < lanes_per_port; b++) begin
            for (int a = 0; a < lanes_per_port; a++) begin
                // modulo 256 wrap comes from the 8-bit add
                acc_next[b*lanes_per_port+a] = out[b*lanes_per_port+a]
                    + acc_t'(pixel[a] & {$bits(pixel_t){weight[b]}});
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            right  <= '0;
            bottom <= '0;
            out    <= '0;
        end else begin
            // systolic pass-through, weights right, pixels down
            if (en) begin
                right  <= left;
                bottom <= up;
            end
            // clear wins over accumulate
            if (clear) begin
                out <= '0;
            end else if (en) begin
                out <= acc_next;
            end
        end
    end

endmodule

//--- skew_feeder.sv
`timescale 1ns/1ps

module skew_feeder #(
    parameter int lanes = 4,
    parameter int width = 12
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         feed_en,
    input  logic [lanes-1:0][width-1:0]  lane_in,
    output logic [lanes-1:0][width-1:0]  lane_out
);

    for (genvar k = 0; k < lanes; k++) begin : g_lane
        // stage 0 is the gated input, stage k drives the output
        logic [width-1:0] stage [0:k];

        // zeros go in outside a vector, so gaps add nothing
        assign stage[0] = feed_en ? lane_in[k] : '0;

        for (genvar s = 1; s <= k; s++) begin : g_stage
            always_ff @(posedge clk) begin
                if (reset) begin
                    stage[s] <= '0;
                end else begin
                    stage[s] <= stage[s-1];
                end
            end
        end

        // lane 0 has no delay
        assign lane_out[k] = stage[k];
    end

endmodule

//--- sa_12_unsigned.sv
`timescale 1ns/1ps

module sa_12_unsigned #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic clear,
    input  logic feed_en,
    input  sa_format_pkg::weight_t [rows-1:0][sa_format_pkg::lanes_per_port-1:0] row_in,
    input  sa_format_pkg::pixel_t  [cols-1:0][sa_format_pkg::lanes_per_port-1:0] column_in,
    output sa_format_pkg::pe_result_t [rows-1:0][cols-1:0] out
);
    import sa_format_pkg::*;

    // packed words before and after the skew
    packed_pixel_t  [cols-1:0] pixel_word;
    packed_weight_t [rows-1:0] weight_word;
    packed_pixel_t  [cols-1:0] pixel_skewed;
    packed_weight_t [rows-1:0] weight_skewed;

    // grid links
    packed_pixel_t  up     [rows-1:0][cols-1:0];
    packed_pixel_t  bottom [rows-1:0][cols-1:0];
    packed_weight_t left   [rows-1:0][cols-1:0];
    packed_weight_t right  [rows-1:0][cols-1:0];

    // place four pixels at their offsets, gaps stay zero
    function automatic packed_pixel_t pack_pixels(input pixel_t [lanes_per_port-1:0] px);
        packed_pixel_t word;
        word = '0;
        for (int a = 0; a < lanes_per_port; a++) begin
            word[pixel_offset[a] +: $bits(pixel_t)] = px[a];
        end
        return word;
    endfunction

    // same for the four weights
    function automatic packed_weight_t pack_weights(input weight_t [lanes_per_port-1:0] wt);
        packed_weight_t word;
        word = '0;
        for (int b = 0; b < lanes_per_port; b++) begin
            word[weight_offset[b]] = wt[b];
        end
        return word;
    endfunction

    always_comb begin
        for (int j = 0; j < cols; j++) begin
            pixel_word[j] = pack_pixels(column_in[j]);
        end
        for (int i = 0; i < rows; i++) begin
            weight_word[i] = pack_weights(row_in[i]);
        end
    end

    // column j waits j cycles
    skew_feeder #(
        .lanes (cols),
        .width ($bits(packed_pixel_t))
    ) i_pixel_skew (
        .clk      (clk),
        .reset    (reset),
        .feed_en  (feed_en),
        .lane_in  (pixel_word),
        .lane_out (pixel_skewed)
    );

    // row i waits i cycles
    skew_feeder #(
        .lanes (rows),
        .width ($bits(packed_weight_t))
    ) i_weight_skew (
        .clk      (clk),
        .reset    (reset),
        .feed_en  (feed_en),
        .lane_in  (weight_word),
        .lane_out (weight_skewed)
    );

    for (genvar i = 0; i < rows; i++) begin : g_row
        for (genvar j = 0; j < cols; j++) begin : g_col
            // top row and left column take the skewed feed
            if (i == 0) begin : g_top
                assign up[i][j] = pixel_skewed[j];
            end else begin : g_below
                assign up[i][j] = bottom[i-1][j];
            end
            if (j == 0) begin : g_edge
                assign left[i][j] = weight_skewed[i];
            end else begin : g_inner
                assign left[i][j] = right[i][j-1];
            end

            pe_12_unsigned i_pe (
                .clk    (clk),
                .reset  (reset),
                .en     (en),
                .clear  (clear),
                .left   (left[i][j]),
                .up     (up[i][j]),
                .right  (right[i][j]),
                .bottom (bottom[i][j]),
                .out    (out[i][j])
            );
        end
    end

endmodule

//--- row_readout.sv
`timescale 1ns/1ps

module row_readout #(
    parameter int rows = 4,
    parameter int cols = 4,
    parameter type row_result_t
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           channel_out_reset,
    input  logic                                           channel_out_en,
    input  sa_format_pkg::pe_result_t [rows-1:0][cols-1:0] all_out,
    output row_result_t                                    row_out,
    output logic                                           row_valid
);
    import sa_format_pkg::*;

    // all ones marks idle, no row selected
    localparam row_index_t ptr_idle = '1;
    localparam row_index_t ptr_last = row_index_t'(rows - 1);

    row_index_t ptr;
    row_index_t ptr_next;

    // idle steps to row 0, last row steps back to idle
    always_comb begin
        if (ptr == ptr_idle) begin
            ptr_next = '0;
        end else if (ptr == ptr_last) begin
            ptr_next = ptr_idle;
        end else begin
            ptr_next = ptr + row_index_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || channel_out_reset) begin
            ptr       <= ptr_idle;
            row_valid <= 1'b0;
        end else begin
            if (channel_out_en) begin
                ptr <= ptr_next;
            end
            // one pulse per strobe, none past the last row
            row_valid <= channel_out_en && (ptr_next != ptr_idle);
        end
    end

    // payload register, loaded only with a real row
    always_ff @(posedge clk) begin
        if (channel_out_en && !channel_out_reset && ptr_next != ptr_idle) begin
            row_out.row_idx <= ptr_next;
            row_out.result  <= all_out[ptr_next];
        end
    end

endmodule

//--- sa_controller.sv
`timescale 1ns/1ps

module sa_controller #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic vector_valid,
    input  logic vector_last,
    output logic acc_clear,
    output logic array_en,
    output logic feed_en,
    output logic busy,
    output logic done
);
    import sa_ctrl_pkg::*;

    // skew adds i+j, PE register adds one, rows+cols covers the far corner
    localparam drain_count_t drain_final = drain_count_t'(rows + cols - 1);

    ctrl_state_t  state;
    ctrl_state_t  state_next;
    drain_count_t drain_cnt;
    logic         drain_last;

    assign drain_last = (state == st_drain) && (drain_cnt == drain_final);

    always_comb begin
        state_next = state;
        case (state)
            // start while busy falls through the other branches
            st_idle: begin
                if (start) begin
                    state_next = st_clear;
                end
            end
            st_clear: begin
                state_next = st_run;
            end
            st_run: begin
                // final vector is still fed this cycle
                if (vector_valid && vector_last) begin
                    state_next = st_drain;
                end
            end
            st_drain: begin
                if (drain_last) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            drain_cnt <= '0;
            done      <= 1'b0;
        end else begin
            state <= state_next;
            // counter only runs inside drain
            drain_cnt <= (state == st_drain) ? drain_cnt + drain_count_t'(1) : '0;
            // lines up with busy falling
            done <= drain_last;
        end
    end

    // decoded from state
    assign acc_clear = (state == st_clear);
    assign array_en  = (state == st_run) || (state == st_drain);
    assign feed_en   = vector_valid && (state == st_run);
    assign busy      = (state != st_idle);

endmodule

//--- sa_tile_top.sv
`timescale 1ns/1ps

module sa_tile_top #(
    parameter int rows = 4,
    parameter int cols = 4,
    // one readout word, row number plus all columns of that row
    parameter type row_result_t = struct packed {
        sa_format_pkg::row_index_t             row_idx;
        sa_format_pkg::pe_result_t [cols-1:0]  result;
    }
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic vector_valid,
    input  logic vector_last,
    input  sa_format_pkg::weight_t [rows-1:0][sa_format_pkg::lanes_per_port-1:0] row_in,
    input  sa_format_pkg::pixel_t  [cols-1:0][sa_format_pkg::lanes_per_port-1:0] column_in,
    input  logic channel_out_reset,
    input  logic channel_out_en,
    output logic busy,
    output logic done,
    output logic row_valid,
    output row_result_t row_out
);
    import sa_format_pkg::*;

    // controller to array
    logic acc_clear;
    logic array_en;
    logic feed_en;

    // every accumulator of the grid
    pe_result_t [rows-1:0][cols-1:0] all_out;

    sa_controller #(
        .rows (rows),
        .cols (cols)
    ) i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .vector_valid (vector_valid),
        .vector_last  (vector_last),
        .acc_clear    (acc_clear),
        .array_en     (array_en),
        .feed_en      (feed_en),
        .busy         (busy),
        .done         (done)
    );

    sa_12_unsigned #(
        .rows (rows),
        .cols (cols)
    ) i_array (
        .clk       (clk),
        .reset     (reset),
        .en        (array_en),
        .clear     (acc_clear),
        .feed_en   (feed_en),
        .row_in    (row_in),
        .column_in (column_in),
        .out       (all_out)
    );

    row_readout #(
        .rows         (rows),
        .cols         (cols),
        .row_result_t (row_result_t)
    ) i_readout (
        .clk               (clk),
        .reset             (reset),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .all_out           (all_out),
        .row_out           (row_out),
        .row_valid         (row_valid)
    );

endmodule

//--- sa_tile_assert.sv
`timescale 1ns/1ps

module sa_tile_assert (
    input logic clk,
    input logic reset,
    input logic start,
    input logic done,
    input logic acc_clear,
    input logic array_en,
    input logic row_valid,
    input logic channel_out_en
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    ) else $error("done stayed high for more than one cycle");

    // start and done never share a cycle
    done_without_start: assert property (
        @(posedge clk) disable iff (reset) !(done && start)
    ) else $error("done seen while start was high");

    // clear cycle hands over to the run state
    clear_then_run: assert property (
        @(posedge clk) disable iff (reset) acc_clear |=> array_en
    ) else $error("array_en not high after acc_clear");

    // each row_valid pulse answers a strobe one cycle earlier
    valid_after_strobe: assert property (
        @(posedge clk) disable iff (reset) row_valid |-> $past(channel_out_en)
    ) else $error("row_valid without channel_out_en in the previous cycle");

endmodule

// internal controller outputs are reached through the bind scope
bind sa_tile_top sa_tile_assert i_assert (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .done           (done),
    .acc_clear      (acc_clear),
    .array_en       (array_en),
    .row_valid      (row_valid),
    .channel_out_en (channel_out_en)
);

//--- tb_sa_tile.sv
`timescale 1ns/1ps

module tb_sa_tile;
    import sa_format_pkg::*;

    localparam int rows = 4;
    localparam int cols = 4;
    localparam int fields = lanes_per_port * lanes_per_port;
    localparam int num_jobs = 6;

    // vector patterns
    localparam logic [1:0] pat_ones   = 2'd0;
    localparam logic [1:0] pat_max    = 2'd1;
    localparam logic [1:0] pat_random = 2'd2;

    // readout orders
    localparam logic [1:0] ro_straight = 2'd0;
    localparam logic [1:0] ro_gapped   = 2'd1;
    localparam logic [1:0] ro_restart  = 2'd2;

    // same layout as the top level default
    typedef struct packed {
        row_index_t            row_idx;
        pe_result_t [cols-1:0] result;
    } row_result_t;

    typedef struct packed {
        logic [15:0] n_vec;
        logic [1:0]  pattern;
        logic [1:0]  readout;
        logic        has_uniform;
        logic [7:0]  uniform;
        logic        gaps;
        logic        start_busy;
    } job_t;

    // vectors, pattern, readout, fixed result, gaps, start while busy
    // 200 x (3 x 1) = 600 wraps to 88
    job_t job_table [num_jobs] = '{
        '{16'd1,   pat_ones,   ro_straight, 1'b1, 8'd1,  1'b0, 1'b0},
        '{16'd200, pat_max,    ro_gapped,   1'b1, 8'd88, 1'b0, 1'b0},
        '{16'd7,   pat_random, ro_restart,  1'b0, 8'd0,  1'b1, 1'b1},
        '{16'd20,  pat_random, ro_straight, 1'b0, 8'd0,  1'b1, 1'b0},
        '{16'd1,   pat_random, ro_gapped,   1'b0, 8'd0,  1'b1, 1'b0},
        '{16'd13,  pat_random, ro_restart,  1'b0, 8'd0,  1'b1, 1'b1}
    };

    logic clk;
    logic reset;
    logic start;
    logic vector_valid;
    logic vector_last;
    weight_t [rows-1:0][lanes_per_port-1:0] row_in;
    pixel_t  [cols-1:0][lanes_per_port-1:0] column_in;
    logic channel_out_reset;
    logic channel_out_en;
    logic busy;
    logic done;
    logic row_valid;
    row_result_t row_out;

    // expected accumulators, indexed row, column, field
    acc_t model_acc [rows][cols][fields];

    int cycle_count;
    int cycle_limit;
    int unsigned rng_init;

    sa_tile_top #(
        .rows         (rows),
        .cols         (cols),
        .row_result_t (row_result_t)
    ) i_dut (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .vector_valid      (vector_valid),
        .vector_last       (vector_last),
        .row_in            (row_in),
        .column_in         (column_in),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .busy              (busy),
        .done              (done),
        .row_valid         (row_valid),
        .row_out           (row_out)
    );

    always #50 clk = ~clk;

    // run limit from the job table
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("run did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_row(input string name, input row_result_t expected,
                             input row_result_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "row mismatch");
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "level mismatch");
        end
    endtask

    function automatic int compute_cycle_limit();
        int total;
        total = 0;
        for (int n = 0; n < num_jobs; n++) begin
            total += int'(job_table[n].n_vec) + rows + cols + rows + 12;
        end
        return total * 2;
    endfunction

    function automatic void clear_model();
        for (int i = 0; i < rows; i++)
            for (int j = 0; j < cols; j++)
                for (int f = 0; f < fields; f++)
                    model_acc[i][j][f] = '0;
    endfunction

    // fixed patterns expect one value in every field
    function automatic void fill_model(input acc_t value);
        for (int i = 0; i < rows; i++)
            for (int j = 0; j < cols; j++)
                for (int f = 0; f < fields; f++)
                    model_acc[i][j][f] = value;
    endfunction

    // field (b,a) of PE(i,j) gains pixel a of column j times weight b of row i
    function automatic void accumulate_model();
        int prod;
        for (int i = 0; i < rows; i++) begin
            for (int j = 0; j < cols; j++) begin
                for (int b = 0; b < lanes_per_port; b++) begin
                    for (int a = 0; a < lanes_per_port; a++) begin
                        prod = int'(column_in[j][a]) * int'(row_in[i][b]);
                        model_acc[i][j][b*lanes_per_port+a] =
                            acc_t'((int'(model_acc[i][j][b*lanes_per_port+a]) + prod) % 256);
                    end
                end
            end
        end
    endfunction

    function automatic row_result_t expected_row(input int r);
        row_result_t e;
        e.row_idx = row_index_t'(r);
        for (int j = 0; j < cols; j++)
            for (int f = 0; f < fields; f++)
                e.result[j][f] = model_acc[r][j][f];
        return e;
    endfunction

    // idle cycle inside a job
    // junk on the lanes must not reach the accumulators
    task automatic drive_gap();
        for (int j = 0; j < cols; j++)
            for (int a = 0; a < lanes_per_port; a++)
                column_in[j][a] = pixel_t'($urandom_range(3, 0));
        for (int i = 0; i < rows; i++)
            for (int b = 0; b < lanes_per_port; b++)
                row_in[i][b] = weight_t'($urandom_range(1, 0));
        vector_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic drive_vector(input logic [1:0] pattern, input logic last,
                                input logic with_start);
        check_level("busy", 1'b1, busy);
        for (int j = 0; j < cols; j++) begin
            for (int a = 0; a < lanes_per_port; a++) begin
                if (pattern == pat_ones)
                    column_in[j][a] = pixel_t'(1);
                else if (pattern == pat_max)
                    column_in[j][a] = pixel_t'(3);
                else
                    column_in[j][a] = pixel_t'($urandom_range(3, 0));
            end
        end
        for (int i = 0; i < rows; i++)
            for (int b = 0; b < lanes_per_port; b++)
                row_in[i][b] = (pattern == pat_random) ? weight_t'($urandom_range(1, 0)) : 1'b1;
        vector_valid = 1'b1;
        vector_last  = last;
        start        = with_start;
        accumulate_model();
        @(negedge clk);
        vector_valid = 1'b0;
        vector_last  = 1'b0;
        start        = 1'b0;
    endtask

    task automatic pulse_out_reset();
        channel_out_reset = 1'b1;
        @(negedge clk);
        channel_out_reset = 1'b0;
        check_level("row_valid", 1'b0, row_valid);
    endtask

    // exp_row below zero means past the last row
    task automatic strobe_row(input int exp_row, input logic gap);
        channel_out_en = 1'b1;
        @(negedge clk);
        channel_out_en = 1'b0;
        check_level("row_valid", exp_row >= 0, row_valid);
        if (exp_row >= 0)
            check_row("row_out", expected_row(exp_row), row_out);
        if (gap) begin
            @(negedge clk);
            check_level("row_valid", 1'b0, row_valid);
        end
    endtask

    task automatic read_rows(input logic [1:0] order);
        pulse_out_reset();
        if (order == ro_restart) begin
            // partial readout, then start over
            strobe_row(0, 1'b0);
            strobe_row(1, 1'b0);
            pulse_out_reset();
        end
        for (int r = 0; r < rows; r++)
            strobe_row(r, order != ro_straight);
        strobe_row(-1, order != ro_straight);
    endtask

    task automatic run_job(input job_t job);
        clear_model();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // clear cycle
        check_level("busy", 1'b1, busy);
        check_level("done", 1'b0, done);
        @(negedge clk);
        for (int v = 0; v < int'(job.n_vec); v++) begin
            if (job.gaps && $urandom_range(1, 0) == 1)
                drive_gap();
            drive_vector(job.pattern, v == int'(job.n_vec) - 1,
                         job.start_busy && v == int'(job.n_vec) / 2);
        end
        // count from the first cycle after vector_last
        for (int n = 1; n <= rows + cols + 1; n++) begin
            if (n > 1)
                @(negedge clk);
            check_level("done", n == rows + cols + 1, done);
            check_level("busy", n != rows + cols + 1, busy);
        end
        @(negedge clk);
        check_level("done", 1'b0, done);
        check_level("busy", 1'b0, busy);
        if (job.has_uniform)
            fill_model(job.uniform);
        read_rows(job.readout);
    endtask

    initial begin
        rng_init          = $urandom(65);
        cycle_count       = 0;
        cycle_limit       = compute_cycle_limit();
        clk               = 1'b0;
        reset             = 1'b1;
        start             = 1'b0;
        vector_valid      = 1'b0;
        vector_last       = 1'b0;
        row_in            = '0;
        column_in         = '0;
        channel_out_reset = 1'b0;
        channel_out_en    = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        // quiet until the first start
        repeat (3) begin
            @(negedge clk);
            check_level("busy", 1'b0, busy);
            check_level("done", 1'b0, done);
            check_level("row_valid", 1'b0, row_valid);
        end
        for (int n = 0; n < num_jobs; n++)
            run_job(job_table[n]);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sa_tile_top.f
sa_format_pkg.sv
sa_ctrl_pkg.sv
pe_12_unsigned.sv
skew_feeder.sv
sa_12_unsigned.sv
row_readout.sv
sa_controller.sv
sa_tile_top.sv
sa_tile_assert.sv
tb_sa_tile.sv

//--- Bender.yml
package:
  name: sa_tile

sources:
  # packages first, the RTL depends on them
  - sa_format_pkg.sv
  - sa_ctrl_pkg.sv
  # array datapath
  - pe_12_unsigned.sv
  - skew_feeder.sv
  - sa_12_unsigned.sv
  # control and readout
  - row_readout.sv
  - sa_controller.sv
  - sa_tile_top.sv
  # verification only
  - target: test
    files:
      - sa_tile_assert.sv
      - tb_sa_tile.sv
